//--- logic/tensor_data_pkg.sv
//////////////////////////////////////////////////////////////////////
// Datapath types for the tensor product engine
// Elements are signed 16-bit integers and sums are signed 40-bit
// Sums wrap modulo 2**ACC_W without saturation
// Up to 7x7 terms of full-scale products cannot reach that limit
//////////////////////////////////////////////////////////////////////
`default_nettype none

package tensor_data_pkg;

  // Element and accumulator widths
  parameter int ELEM_W = 16;
  parameter int ACC_W  = 40;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // One multiply job for the datapath, 34 bits
  // first opens a new sum, last closes it
  typedef struct packed {
    elem_t a;
    elem_t b;
    logic  first;
    logic  last;
  } operand_pair_t;

  // Sign-extended product with the sum markers carried along
  typedef struct packed {
    acc_t prod;
    logic first;
    logic last;
  } product_t;

  // Output element of C, 43 bits
  typedef struct packed {
    acc_t value;
    logic end_row;
    logic end_slice;
    logic end_tensor;
  } result_t;

endpackage

`default_nettype wire

//--- logic/tensor_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Control types for the tensor product engine
// Sizes and indices are 3 bits wide, so one dimension holds 1 to 7
// A size of zero is not a valid job
//////////////////////////////////////////////////////////////////////
`default_nettype none

package tensor_ctrl_pkg;

  // Size or running index in one dimension
  typedef logic [2:0] dim_t;

  // Job descriptor, 12 bits
  // A is I x L x K, B is L x J x K, C is I x J x K
  typedef struct packed {
    dim_t size_i;
    dim_t size_j;
    dim_t size_k;
    dim_t size_l;
  } job_t;

  // Index record kept per pending sum
  // Same field order as the flag bits of result_t
  typedef struct packed {
    logic end_row;
    logic end_slice;
    logic end_tensor;
  } flag_rec_t;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_ISSUE,
    ST_DRAIN
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/stream_slice.sv
//////////////////////////////////////////////////////////////////////
// Single-entry valid/ready register slice for any payload type
// Full throughput, one item per cycle while out_ready stays high
// in_ready depends combinationally on out_ready
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module stream_slice #(
  parameter type T = logic
) (
  input  logic CLK,
  input  logic RST,

  // Upstream side
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,

  // Downstream side
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  // Free when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Payload register
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/operand_store.sv
//////////////////////////////////////////////////////////////////////
// Operand memories for tensors A and B
// A is taken first in full, then B, both written in arrival order
// Address of A is (k*I + i)*L + l, address of B is (k*L + l)*J + j
// Reads are combinational, so the memories map to distributed RAM
// job must be stable from the cycle after load_start
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_store
  import tensor_data_pkg::*;
  import tensor_ctrl_pkg::*;
#(
  parameter  int MAX_DIM = 4,
  localparam int AW      = $clog2(MAX_DIM ** 3)
) (
  input  logic          CLK,
  input  logic          RST,

  // Job sizes and load trigger
  input  job_t          job,
  input  logic          load_start,

  // Element streams
  input  logic          a_valid,
  output logic          a_ready,
  input  elem_t         a_data,
  input  logic          b_valid,
  output logic          b_ready,
  input  elem_t         b_data,

  // Both tensors in place
  output logic          loaded,

  // Read ports
  input  logic [AW-1:0] a_addr,
  input  logic [AW-1:0] b_addr,
  output elem_t         a_rdata,
  output elem_t         b_rdata
);

  localparam int DEPTH = MAX_DIM ** 3;
  // Wide enough for 7*7*7 elements
  localparam int CNT_W = 3 * $bits(dim_t);

  elem_t            mem_a [DEPTH];
  elem_t            mem_b [DEPTH];
  logic [CNT_W-1:0] wr_cnt;
  logic [CNT_W-1:0] a_total;
  logic [CNT_W-1:0] b_total;
  logic             a_fire;
  logic             b_fire;

  // Element counts of the current job
  assign a_total = CNT_W'(job.size_i) * CNT_W'(job.size_l) * CNT_W'(job.size_k);
  assign b_total = CNT_W'(job.size_l) * CNT_W'(job.size_j) * CNT_W'(job.size_k);

  assign a_fire = a_valid && a_ready;
  assign b_fire = b_valid && b_ready;

  //////////////////////////////////////////////////////////////////////
  // Load sequencing
  //////////////////////////////////////////////////////////////////////

  // a_ready and b_ready double as the phase flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_ready <= 1'b0;
      b_ready <= 1'b0;
      loaded  <= 1'b0;
      wr_cnt  <= '0;
    end else if (load_start) begin
      a_ready <= 1'b1;
      b_ready <= 1'b0;
      loaded  <= 1'b0;
      wr_cnt  <= '0;
    end else if (a_fire) begin
      if (wr_cnt == a_total - 1'b1) begin
        // A done, B reuses the counter
        a_ready <= 1'b0;
        b_ready <= 1'b1;
        wr_cnt  <= '0;
      end else begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end else if (b_fire) begin
      if (wr_cnt == b_total - 1'b1) begin
        b_ready <= 1'b0;
        loaded  <= 1'b1;
        wr_cnt  <= '0;
      end else begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memories
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (a_fire) begin
      mem_a[AW'(wr_cnt)] <= a_data;
    end
    if (b_fire) begin
      mem_b[AW'(wr_cnt)] <= b_data;
    end
  end

  assign a_rdata = mem_a[a_addr];
  assign b_rdata = mem_b[b_addr];

endmodule

`default_nettype wire

//--- logic/scalar_multiplier.sv
//////////////////////////////////////////////////////////////////////
// Two-stage pipelined signed 16x16 multiplier
// Latency is 2 cycles without stalls, at most 2 items in flight
// The product is sign-extended to the accumulator width
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_multiplier
  import tensor_data_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,

  // Operand pairs in
  input  logic          in_valid,
  output logic          in_ready,
  input  operand_pair_t in_data,

  // Products out
  output logic          out_valid,
  input  logic          out_ready,
  output product_t      out_data
);

  operand_pair_t              s1_data;
  logic                       s1_valid;
  logic                       s1_free;
  logic                       s2_free;
  logic signed [2*ELEM_W-1:0] s1_prod;

  // Each stage moves when the one after it is empty or draining
  assign s2_free  = !out_valid || out_ready;
  assign s1_free  = !s1_valid || s2_free;
  assign in_ready = s1_free;

  // Both operands signed, full 32-bit result
  assign s1_prod = s1_data.a * s1_data.b;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid <= in_valid;
      end
      if (s2_free) begin
        out_valid <= s1_valid;
      end
    end
  end

  // Stage registers
  always_ff @(posedge CLK) begin
    if (in_valid && s1_free) begin
      s1_data <= in_data;
    end
    if (s1_valid && s2_free) begin
      out_data <= '{prod: acc_t'(s1_prod), first: s1_data.first, last: s1_data.last};
    end
  end

endmodule

`default_nettype wire

//--- logic/scalar_accumulator.sv
//////////////////////////////////////////////////////////////////////
// Accumulates a run of products between first and last markers
// The sum is valid the cycle after the last product is taken
// The input stalls while a finished sum waits downstream
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_accumulator
  import tensor_data_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,

  // Products in
  input  logic     in_valid,
  output logic     in_ready,
  input  product_t in_data,

  // Finished sums out
  output logic     out_valid,
  input  logic     out_ready,
  output acc_t     out_data
);

  logic in_fire;

  // A new product may enter in the cycle the held sum leaves
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      // Set only when this product closes the sum
      out_valid <= in_data.last;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Running sum, also the output register
  always_ff @(posedge CLK) begin
    if (in_fire) begin
      if (in_data.first) begin
        out_data <= in_data.prod;
      end else begin
        out_data <= out_data + in_data.prod;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/tensor_product_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Job controller of the tensor product engine
// One job at a time with no overlap of loading and computing
// Issue order is k, i, j, then l innermost
// Output flags wait in a 4-entry FIFO with one entry per pending sum
// job_ready returns only after c takes the end_tensor result
// Sizes above MAX_DIM are outside the contract
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tensor_product_ctrl
  import tensor_data_pkg::*;
  import tensor_ctrl_pkg::*;
#(
  parameter  int MAX_DIM = 4,
  localparam int AW      = $clog2(MAX_DIM ** 3)
) (
  input  logic          CLK,
  input  logic          RST,

  // Job stream
  input  logic          job_valid,
  output logic          job_ready,
  input  job_t          job_data,

  // Operand store
  output logic          load_start,
  input  logic          loaded,
  output job_t          job_size,
  output logic [AW-1:0] a_addr,
  output logic [AW-1:0] b_addr,
  input  elem_t         a_rdata,
  input  elem_t         b_rdata,

  // Operand pairs to the multiplier
  output logic          pair_valid,
  input  logic          pair_ready,
  output operand_pair_t pair_data,

  // Sums from the accumulator
  input  logic          sum_valid,
  output logic          sum_ready,
  input  acc_t          sum_data,

  // Flagged results
  output logic          res_valid,
  input  logic          res_ready,
  output result_t       res_data
);

  localparam int FIFO_DEPTH = 4;
  localparam int PW         = $clog2(FIFO_DEPTH);

  ctrl_state_t  state;
  dim_t         idx_i;
  dim_t         idx_j;
  dim_t         idx_k;
  dim_t         idx_l;
  logic         i_end;
  logic         j_end;
  logic         k_end;
  logic         l_end;
  logic         job_fire;
  logic         pair_fire;
  logic         res_fire;

  flag_rec_t    fifo_mem [FIFO_DEPTH];
  flag_rec_t    fifo_head;
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]  fifo_cnt;
  logic         fifo_push;
  logic         fifo_full;
  logic         fifo_empty;

  // Zero-extend an index or size to address width
  function automatic logic [AW-1:0] ext(input dim_t d);
    return AW'(d);
  endfunction

  assign job_fire   = job_valid && job_ready;
  assign load_start = job_fire;

  // Last index in each dimension
  assign i_end = (idx_i == job_size.size_i - 3'd1);
  assign j_end = (idx_j == job_size.size_j - 3'd1);
  assign k_end = (idx_k == job_size.size_k - 3'd1);
  assign l_end = (idx_l == job_size.size_l - 3'd1);

  //////////////////////////////////////////////////////////////////////
  // Operand issue
  //////////////////////////////////////////////////////////////////////

  assign a_addr = (ext(idx_k) * ext(job_size.size_i) + ext(idx_i)) * ext(job_size.size_l)
                  + ext(idx_l);
  assign b_addr = (ext(idx_k) * ext(job_size.size_l) + ext(idx_l)) * ext(job_size.size_j)
                  + ext(idx_j);

  // Hold back while every FIFO slot has a pending sum
  assign pair_valid = (state == ST_ISSUE) && !fifo_full;
  assign pair_fire  = pair_valid && pair_ready;
  assign pair_data  = '{a: a_rdata, b: b_rdata, first: (idx_l == 3'd0), last: l_end};

  //////////////////////////////////////////////////////////////////////
  // Flag FIFO
  //////////////////////////////////////////////////////////////////////

  // One record per sum pushed with its last pair
  assign fifo_push  = pair_fire && l_end;
  assign fifo_full  = (fifo_cnt == (PW+1)'(FIFO_DEPTH));
  assign fifo_empty = (fifo_cnt == '0);
  assign fifo_head  = fifo_mem[rd_ptr];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (res_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({fifo_push, res_fire})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr] <= '{end_row: j_end, end_slice: j_end && i_end,
                            end_tensor: j_end && i_end && k_end};
    end
  end

  // Sums return in issue order and match the FIFO head
  assign res_valid = sum_valid && !fifo_empty;
  assign sum_ready = res_ready && !fifo_empty;
  assign res_fire  = res_valid && res_ready;
  assign res_data  = '{value: sum_data, end_row: fifo_head.end_row,
                       end_slice: fifo_head.end_slice, end_tensor: fifo_head.end_tensor};

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  // Job sizes held for the whole job
  always_ff @(posedge CLK) begin
    if (job_fire) begin
      job_size <= job_data;
    end
  end

  // Indices wrap to zero at the end of a tensor
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      job_ready <= 1'b0;
      idx_i     <= '0;
      idx_j     <= '0;
      idx_k     <= '0;
      idx_l     <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (job_fire) begin
            state     <= ST_LOAD;
            job_ready <= 1'b0;
          end else begin
            job_ready <= 1'b1;
          end
        end
        ST_LOAD: begin
          // Store fills A then B
          if (loaded) begin
            state <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (pair_fire) begin
            idx_l <= l_end ? '0 : idx_l + 3'd1;
            if (l_end) begin
              idx_j <= j_end ? '0 : idx_j + 3'd1;
              if (j_end) begin
                idx_i <= i_end ? '0 : idx_i + 3'd1;
                if (i_end) begin
                  idx_k <= k_end ? '0 : idx_k + 3'd1;
                  if (k_end) begin
                    state <= ST_DRAIN;
                  end
                end
              end
            end
          end
        end
        ST_DRAIN: begin
          // Empty FIFO means the end_tensor result sits in the output slice
          // The slice frees on the c transfer that ends the job
          if (fifo_empty && res_ready) begin
            state     <= ST_IDLE;
            job_ready <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/tensor_product_top.sv
//////////////////////////////////////////////////////////////////////
// Tensor product engine, C[i][j][k] = sum over l of A[i][l][k]*B[l][j][k]
// A arrives as k, i, l and B as k, l, j, innermost index last
// C leaves as k, i, j with end_row, end_slice and end_tensor flags
// MAX_DIM bounds every size and sets the memory depth to MAX_DIM**3
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tensor_product_top
  import tensor_data_pkg::*;
  import tensor_ctrl_pkg::*;
#(
  parameter int MAX_DIM = 4
) (
  input  logic    CLK,
  input  logic    RST,

  input  logic    job_valid,
  output logic    job_ready,
  input  job_t    job_data,

  input  logic    a_valid,
  output logic    a_ready,
  input  elem_t   a_data,

  input  logic    b_valid,
  output logic    b_ready,
  input  elem_t   b_data,

  output logic    c_valid,
  input  logic    c_ready,
  output result_t c_data
);

  localparam int AW = $clog2(MAX_DIM ** 3);

  // Store link
  job_t          job_size;
  logic          load_start;
  logic          loaded;
  logic [AW-1:0] a_addr;
  logic [AW-1:0] b_addr;
  elem_t         a_rdata;
  elem_t         b_rdata;

  // Datapath links
  logic          pair_valid;
  logic          pair_ready;
  operand_pair_t pair_data;
  logic          mul_valid;
  logic          mul_ready;
  operand_pair_t mul_data;
  logic          prod_valid;
  logic          prod_ready;
  product_t      prod_data;
  logic          sum_valid;
  logic          sum_ready;
  acc_t          sum_data;
  logic          res_valid;
  logic          res_ready;
  result_t       res_data;

  operand_store #(.MAX_DIM(MAX_DIM)) u_operand_store (
    .CLK(CLK), .RST(RST),
    .job(job_size), .load_start(load_start),
    .a_valid(a_valid), .a_ready(a_ready), .a_data(a_data),
    .b_valid(b_valid), .b_ready(b_ready), .b_data(b_data),
    .loaded(loaded),
    .a_addr(a_addr), .b_addr(b_addr), .a_rdata(a_rdata), .b_rdata(b_rdata)
  );

  tensor_product_ctrl #(.MAX_DIM(MAX_DIM)) u_ctrl (
    .CLK(CLK), .RST(RST),
    .job_valid(job_valid), .job_ready(job_ready), .job_data(job_data),
    .load_start(load_start), .loaded(loaded), .job_size(job_size),
    .a_addr(a_addr), .b_addr(b_addr), .a_rdata(a_rdata), .b_rdata(b_rdata),
    .pair_valid(pair_valid), .pair_ready(pair_ready), .pair_data(pair_data),
    .sum_valid(sum_valid), .sum_ready(sum_ready), .sum_data(sum_data),
    .res_valid(res_valid), .res_ready(res_ready), .res_data(res_data)
  );

  // Cuts the memory read path ahead of the multiplier
  stream_slice #(.T(operand_pair_t)) u_pair_slice (
    .CLK(CLK), .RST(RST),
    .in_valid(pair_valid), .in_ready(pair_ready), .in_data(pair_data),
    .out_valid(mul_valid), .out_ready(mul_ready), .out_data(mul_data)
  );

  scalar_multiplier u_multiplier (
    .CLK(CLK), .RST(RST),
    .in_valid(mul_valid), .in_ready(mul_ready), .in_data(mul_data),
    .out_valid(prod_valid), .out_ready(prod_ready), .out_data(prod_data)
  );

  scalar_accumulator u_accumulator (
    .CLK(CLK), .RST(RST),
    .in_valid(prod_valid), .in_ready(prod_ready), .in_data(prod_data),
    .out_valid(sum_valid), .out_ready(sum_ready), .out_data(sum_data)
  );

  // Registered output stream
  stream_slice #(.T(result_t)) u_out_slice (
    .CLK(CLK), .RST(RST),
    .in_valid(res_valid), .in_ready(res_ready), .in_data(res_data),
    .out_valid(c_valid), .out_ready(c_ready), .out_data(c_data)
  );

endmodule

`default_nettype wire

//--- bench/tensor_product_properties.sv
//////////////////////////////////////////////////////////////////////
// Handshake checks on the controller of the tensor product engine
// Bound into every tensor_product_ctrl instance
// Assumes the job source keeps valid and payload until the transfer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tensor_product_properties
  import tensor_data_pkg::*;
  import tensor_ctrl_pkg::*;
(
  input logic          CLK,
  input logic          RST,
  input logic          job_valid,
  input logic          job_ready,
  input job_t          job_data,
  input logic          pair_valid,
  input logic          pair_ready,
  input operand_pair_t pair_data,
  input logic          res_valid,
  input logic          res_ready,
  input result_t       res_data
);

  // Stalled job stream holds its request
  job_hold: assert property (@(posedge CLK) disable iff (RST)
    job_valid && !job_ready |=> job_valid && $stable(job_data))
    else $error("job stream changed while stalled");

  // Operand pair waits unchanged for the register slice
  pair_hold: assert property (@(posedge CLK) disable iff (RST)
    pair_valid && !pair_ready |=> pair_valid && $stable(pair_data))
    else $error("operand pair changed while stalled");

  // Result waits unchanged for the output slice
  res_hold: assert property (@(posedge CLK) disable iff (RST)
    res_valid && !res_ready |=> res_valid && $stable(res_data))
    else $error("result changed while stalled");

  // Nothing offered or accepted under reset
  reset_quiet: assert property (@(posedge CLK) RST |-> !job_ready && !res_valid)
    else $error("job_ready or res_valid high during reset");

endmodule

bind tensor_product_ctrl tensor_product_properties u_properties (
  .CLK(CLK), .RST(RST),
  .job_valid(job_valid), .job_ready(job_ready), .job_data(job_data),
  .pair_valid(pair_valid), .pair_ready(pair_ready), .pair_data(pair_data),
  .res_valid(res_valid), .res_ready(res_ready), .res_data(res_data)
);

`default_nettype wire

//--- bench/tb_tensor_product.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the tensor product engine with MAX_DIM 4
// Job sizes stay within 1 to 4 and all stimulus is made up front
// Inputs change on the falling edge and outputs are read there too
// Random gaps on a and b and random low cycles on c_ready
// Timeout scales with the total job length
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_product
  import tensor_data_pkg::*;
  import tensor_ctrl_pkg::*;
();

  localparam int MAX_DIM  = 4;
  localparam int NUM_JOBS = 43;

  logic    CLK;
  logic    RST;
  logic    job_valid;
  logic    job_ready;
  job_t    job_data;
  logic    a_valid;
  logic    a_ready;
  elem_t   a_data;
  logic    b_valid;
  logic    b_ready;
  elem_t   b_data;
  logic    c_valid;
  logic    c_ready;
  result_t c_data;

  // Stimulus and model state
  integer  seed = 32'h329b;
  integer  seed_a;
  integer  seed_b;
  integer  seed_c;
  job_t    job_list [$];
  elem_t   a_q [$];
  elem_t   b_q [$];
  result_t exp_q [$];
  job_t    cur_job;
  logic    job_busy = 1'b0;
  int      total_results = 0;
  int      results_seen = 0;
  int      cycle_cnt = 0;
  int      timeout_limit = 0;

  tensor_product_top #(.MAX_DIM(MAX_DIM)) u_tensor_product_top (
    .CLK(CLK), .RST(RST),
    .job_valid(job_valid), .job_ready(job_ready), .job_data(job_data),
    .a_valid(a_valid), .a_ready(a_ready), .a_data(a_data),
    .b_valid(b_valid), .b_ready(b_ready), .b_data(b_data),
    .c_valid(c_valid), .c_ready(c_ready), .c_data(c_data)
  );

  // 20 ns clock
  always #10 CLK = ~CLK;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Watchdog
  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit)
      abort_run($sformatf("Timeout, run did not finish within %0d cycles", timeout_limit));
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // 0 random, 1 all minimum, 2 minimum or maximum at random
  function automatic elem_t make_elem(input int mode);
    if (mode == 1)
      return 16'sh8000;
    if (mode == 2)
      return (($random(seed) & 1) != 0) ? 16'sh7fff : 16'sh8000;
    return elem_t'($random(seed));
  endfunction

  // A[i][l][k] and B[l][j][k] held with natural indices
  task automatic add_job(input job_t jb, input int mode);
    elem_t   a_t [MAX_DIM][MAX_DIM][MAX_DIM];
    elem_t   b_t [MAX_DIM][MAX_DIM][MAX_DIM];
    longint  acc;
    result_t r;
    // A order is k, i, l
    for (int k = 0; k < int'(jb.size_k); k++)
      for (int i = 0; i < int'(jb.size_i); i++)
        for (int l = 0; l < int'(jb.size_l); l++) begin
          a_t[i][l][k] = make_elem(mode);
          a_q.push_back(a_t[i][l][k]);
        end
    // B order is k, l, j
    for (int k = 0; k < int'(jb.size_k); k++)
      for (int l = 0; l < int'(jb.size_l); l++)
        for (int j = 0; j < int'(jb.size_j); j++) begin
          b_t[l][j][k] = make_elem(mode);
          b_q.push_back(b_t[l][j][k]);
        end
    // C order is k, i, j with flags at row, slice and tensor ends
    for (int k = 0; k < int'(jb.size_k); k++)
      for (int i = 0; i < int'(jb.size_i); i++)
        for (int j = 0; j < int'(jb.size_j); j++) begin
          acc = 0;
          for (int l = 0; l < int'(jb.size_l); l++)
            acc += longint'(a_t[i][l][k]) * longint'(b_t[l][j][k]);
          r.value      = acc_t'(acc);
          r.end_row    = (j == int'(jb.size_j) - 1);
          r.end_slice  = r.end_row && (i == int'(jb.size_i) - 1);
          r.end_tensor = r.end_slice && (k == int'(jb.size_k) - 1);
          exp_q.push_back(r);
        end
    job_list.push_back(jb);
  endtask

  task automatic build_jobs();
    job_t jb;
    int   mode;
    int   budget;
    budget = 0;
    for (int n = 0; n < NUM_JOBS; n++) begin
      mode = 0;
      if (n == 0) begin
        jb = '{size_i: 3'd1, size_j: 3'd1, size_k: 3'd1, size_l: 3'd1};
      end else if (n >= NUM_JOBS - 2) begin
        // Full-scale operands at the largest sizes
        jb   = '{size_i: 3'd4, size_j: 3'd4, size_k: 3'd4, size_l: 3'd4};
        mode = (n == NUM_JOBS - 2) ? 1 : 2;
      end else begin
        jb.size_i = dim_t'(($random(seed) & 3) + 1);
        jb.size_j = dim_t'(($random(seed) & 3) + 1);
        jb.size_k = dim_t'(($random(seed) & 3) + 1);
        jb.size_l = dim_t'(($random(seed) & 3) + 1);
      end
      add_job(jb, mode);
      // Load of A and B plus one pair per product and pipeline drain
      budget += int'(jb.size_i) * int'(jb.size_l) * int'(jb.size_k)
              + int'(jb.size_l) * int'(jb.size_j) * int'(jb.size_k)
              + int'(jb.size_i) * int'(jb.size_j) * int'(jb.size_k) * int'(jb.size_l) + 8;
    end
    total_results = exp_q.size();
    timeout_limit = 4 * budget + 1000;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_result(input result_t got, input result_t exp);
    if (got.value !== exp.value)
      abort_run($sformatf("Mismatch c_data.value got %h expected %h at result %0d",
                          got.value, exp.value, results_seen));
    if (got.end_row !== exp.end_row)
      abort_run($sformatf("Mismatch c_data.end_row got %h expected %h at result %0d",
                          got.end_row, exp.end_row, results_seen));
    if (got.end_slice !== exp.end_slice)
      abort_run($sformatf("Mismatch c_data.end_slice got %h expected %h at result %0d",
                          got.end_slice, exp.end_slice, results_seen));
    if (got.end_tensor !== exp.end_tensor)
      abort_run($sformatf("Mismatch c_data.end_tensor got %h expected %h at result %0d",
                          got.end_tensor, exp.end_tensor, results_seen));
  endtask

  // A job in progress keeps the job stream closed
  task automatic check_idle(input job_t pending);
    if (job_ready !== 1'b0)
      abort_run($sformatf("job_ready went high while job %0dx%0dx%0dx%0d was still running",
                          pending.size_i, pending.size_j, pending.size_k, pending.size_l));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers and output monitor
  //////////////////////////////////////////////////////////////////////

  // Registered ready signals hold their negedge value to the next edge
  task automatic drive_jobs();
    foreach (job_list[n]) begin
      job_valid = 1'b1;
      job_data  = job_list[n];
      while (!job_ready) @(negedge CLK);
      @(negedge CLK);
      job_valid = 1'b0;
      cur_job   = job_list[n];
      job_busy  = 1'b1;
    end
  endtask

  task automatic drive_a();
    elem_t v;
    while (a_q.size() > 0) begin
      v = a_q.pop_front();
      while (($random(seed_a) & 3) == 0) begin
        a_valid = 1'b0;
        @(negedge CLK);
      end
      a_valid = 1'b1;
      a_data  = v;
      while (!a_ready) @(negedge CLK);
      @(negedge CLK);
    end
    a_valid = 1'b0;
  endtask

  task automatic drive_b();
    elem_t v;
    while (b_q.size() > 0) begin
      v = b_q.pop_front();
      while (($random(seed_b) & 3) == 0) begin
        b_valid = 1'b0;
        @(negedge CLK);
      end
      b_valid = 1'b1;
      b_data  = v;
      while (!b_ready) @(negedge CLK);
      @(negedge CLK);
    end
    b_valid = 1'b0;
  endtask

  // A result is taken at the next rising edge when valid and ready meet here
  task automatic watch_c();
    result_t exp;
    forever begin
      @(negedge CLK);
      c_ready = (($random(seed_c) & 3) != 0);
      if (job_busy)
        check_idle(cur_job);
      if (c_valid && c_ready) begin
        if (exp_q.size() == 0)
          abort_run("DUT sent a result that the model does not expect");
        exp = exp_q.pop_front();
        check_result(c_data, exp);
        results_seen++;
        if (c_data.end_tensor)
          job_busy = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    job_valid = 1'b0;
    job_data  = '0;
    a_valid   = 1'b0;
    a_data    = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    c_ready   = 1'b0;
    build_jobs();
    seed_a = seed ^ 32'h0000_1a1a;
    seed_b = seed ^ 32'h0000_2b2b;
    seed_c = seed ^ 32'h0000_3c3c;

    // Outputs stay quiet through 16 cycles of reset
    repeat (16) begin
      @(negedge CLK);
      if (job_ready || a_ready || b_ready || c_valid)
        abort_run("A ready or valid output was high during reset");
    end
    RST = 1'b0;
    @(negedge CLK);
    if (!job_ready)
      abort_run("job_ready did not rise on the first edge after reset");

    fork
      drive_jobs();
      drive_a();
      drive_b();
      watch_c();
    join_none

    while (results_seen < total_results) @(negedge CLK);
    repeat (4) @(negedge CLK);
    if (c_valid)
      abort_run("DUT offered a result after the last job had finished");

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tensor_product.f
logic/tensor_data_pkg.sv
logic/tensor_ctrl_pkg.sv
logic/stream_slice.sv
logic/operand_store.sv
logic/scalar_multiplier.sv
logic/scalar_accumulator.sv
logic/tensor_product_ctrl.sv
logic/tensor_product_top.sv
bench/tensor_product_properties.sv
bench/tb_tensor_product.sv

//--- Makefile
# Verilator build and run of the tensor product engine testbench

VERILATOR ?= verilator
TOP       ?= tb_tensor_product
FILELIST  ?= tensor_product.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard logic/*.sv bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log holds the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "FAIL, simulator exit status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
